/* common/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// ******************************
// widths and sizes.
// ******************************
`define WORD_WIDTH      32
`define HALF_WIDTH      16
`define REG_ADDR_WIDTH  5
`define REG_COUNT       32
`define OPCODE_WIDTH    6
`define FUNCT_WIDTH     6
`define SHAMT_WIDTH     5
`define ALU_OP_WIDTH    4

// primary opcodes.
`define OPC_RTYPE  6'h00
`define OPC_ADDIU  6'h09
`define OPC_SLTI   6'h0a
`define OPC_SLTIU  6'h0b
`define OPC_ANDI   6'h0c
`define OPC_ORI    6'h0d
`define OPC_XORI   6'h0e
`define OPC_LUI    6'h0f

// r-type funct field.
`define FN_SLL   6'h00
`define FN_SRL   6'h02
`define FN_SRA   6'h03
`define FN_ADDU  6'h21
`define FN_SUBU  6'h23
`define FN_AND   6'h24
`define FN_OR    6'h25
`define FN_XOR   6'h26
`define FN_NOR   6'h27
`define FN_SLT   6'h2a
`define FN_SLTU  6'h2b

// alu operation codes.
`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_AND   4'd2
`define ALU_OR    4'd3
`define ALU_XOR   4'd4
`define ALU_NOR   4'd5
`define ALU_SLT   4'd6
`define ALU_SLTU  4'd7
`define ALU_SLL   4'd8
`define ALU_SRL   4'd9
`define ALU_SRA   4'd10
`define ALU_LUI   4'd11

`endif

/* common/mips_pkg.sv */
`default_nettype none

`include "mips_defs.svh"

package mips_pkg;

    // ******************************
    // datapath types.
    // ******************************

    // data or instruction word.
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // register index.
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // ******************************
    // instruction fields.
    // ******************************

    typedef logic [`OPCODE_WIDTH-1:0] opcode_t;
    typedef logic [`FUNCT_WIDTH-1:0] funct_t;
    typedef logic [`SHAMT_WIDTH-1:0] shamt_t;

    // selects the alu function.
    typedef logic [`ALU_OP_WIDTH-1:0] alu_op_t;

endpackage

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module regfile (
    input  logic               clk,
    input  logic               reset,
    input  logic               clk_enable,
    // write strobe from the decoder.
    input  logic               write_control,
    // read addresses.
    input  mips_pkg::reg_addr_t read_reg1,
    input  mips_pkg::reg_addr_t read_reg2,
    // write address and data.
    input  mips_pkg::reg_addr_t write_reg,
    input  mips_pkg::word_t     write_data,
    // combinational read data.
    output mips_pkg::word_t     read_data1,
    output mips_pkg::word_t     read_data2
);

    // ******************************
    // storage.
    // ******************************

    mips_pkg::word_t registers [`REG_COUNT];

    logic write_allowed;

    // $0 is never a write target.
    assign write_allowed = write_control && (write_reg != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (clk_enable) begin
            if (write_allowed) begin
                registers[write_reg] <= write_data;
            end
        end
    end

    // ******************************
    // read ports.
    // ******************************

    // $0 always reads as zero.
    always_comb begin
        if (read_reg1 == '0) begin
            read_data1 = '0;
        end else begin
            read_data1 = registers[read_reg1];
        end
    end

    always_comb begin
        if (read_reg2 == '0) begin
            read_data2 = '0;
        end else begin
            read_data2 = registers[read_reg2];
        end
    end

endmodule

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module alu (
    input  mips_pkg::word_t   operand_a,
    input  mips_pkg::word_t   operand_b,
    input  mips_pkg::shamt_t  shamt,
    input  mips_pkg::alu_op_t alu_op,
    output mips_pkg::word_t   alu_result
);

    // ******************************
    // shared intermediates.
    // ******************************

    mips_pkg::word_t sum;
    mips_pkg::word_t diff;
    mips_pkg::word_t shift_left;
    mips_pkg::word_t shift_right;
    mips_pkg::word_t shift_arith;
    mips_pkg::word_t upper_imm;
    logic            lt_signed;
    logic            lt_unsigned;

    // wraps modulo 2^32, no overflow trap.
    assign sum  = operand_a + operand_b;
    assign diff = operand_a - operand_b;

    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    // shifts act on the rt operand.
    assign shift_left  = operand_b << shamt;
    assign shift_right = operand_b >> shamt;
    assign shift_arith = $signed(operand_b) >>> shamt;

    // low half of the immediate moves to the top.
    assign upper_imm = {operand_b[`HALF_WIDTH-1:0], {`HALF_WIDTH{1'b0}}};

    // ******************************
    // result select.
    // ******************************

    always_comb begin
        case (alu_op)
            `ALU_ADD:  alu_result = sum;
            `ALU_SUB:  alu_result = diff;
            `ALU_AND:  alu_result = operand_a & operand_b;
            `ALU_OR:   alu_result = operand_a | operand_b;
            `ALU_XOR:  alu_result = operand_a ^ operand_b;
            `ALU_NOR:  alu_result = ~(operand_a | operand_b);
            `ALU_SLT: begin
                alu_result = {{(`WORD_WIDTH-1){1'b0}}, lt_signed};
            end
            `ALU_SLTU: begin
                alu_result = {{(`WORD_WIDTH-1){1'b0}}, lt_unsigned};
            end
            `ALU_SLL:  alu_result = shift_left;
            `ALU_SRL:  alu_result = shift_right;
            `ALU_SRA:  alu_result = shift_arith;
            `ALU_LUI:  alu_result = upper_imm;
            // unused codes.
            default:   alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module instr_decode (
    input  mips_pkg::word_t     instr,
    input  logic                instr_valid,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output mips_pkg::reg_addr_t dest_reg,
    output mips_pkg::shamt_t    shamt,
    output mips_pkg::alu_op_t   alu_op,
    output logic                use_imm,
    output mips_pkg::word_t     imm_value,
    output logic                write_control,
    output logic                illegal_instr
);

    // ******************************
    // field extraction.
    // ******************************

    mips_pkg::opcode_t          opcode;
    mips_pkg::funct_t           funct;
    mips_pkg::reg_addr_t        rd;
    logic [`HALF_WIDTH-1:0]     imm16;
    logic                       sign_ext;
    logic                       legal;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];

    // ******************************
    // operation select.
    // ******************************

    always_comb begin
        alu_op   = `ALU_ADD;
        use_imm  = 1'b1;
        sign_ext = 1'b0;
        legal    = 1'b1;
        dest_reg = rt;

        case (opcode)
            `OPC_RTYPE: begin
                use_imm  = 1'b0;
                dest_reg = rd;
                case (funct)
                    `FN_SLL:  alu_op = `ALU_SLL;
                    `FN_SRL:  alu_op = `ALU_SRL;
                    `FN_SRA:  alu_op = `ALU_SRA;
                    `FN_ADDU: alu_op = `ALU_ADD;
                    `FN_SUBU: alu_op = `ALU_SUB;
                    `FN_AND:  alu_op = `ALU_AND;
                    `FN_OR:   alu_op = `ALU_OR;
                    `FN_XOR:  alu_op = `ALU_XOR;
                    `FN_NOR:  alu_op = `ALU_NOR;
                    `FN_SLT:  alu_op = `ALU_SLT;
                    `FN_SLTU: alu_op = `ALU_SLTU;
                    default:  legal  = 1'b0;
                endcase
            end
            // arithmetic and compares sign-extend.
            `OPC_ADDIU: begin
                alu_op   = `ALU_ADD;
                sign_ext = 1'b1;
            end
            `OPC_SLTI: begin
                alu_op   = `ALU_SLT;
                sign_ext = 1'b1;
            end
            `OPC_SLTIU: begin
                alu_op   = `ALU_SLTU;
                sign_ext = 1'b1;
            end
            // logical ops zero-extend.
            `OPC_ANDI: alu_op = `ALU_AND;
            `OPC_ORI:  alu_op = `ALU_OR;
            `OPC_XORI: alu_op = `ALU_XOR;
            `OPC_LUI:  alu_op = `ALU_LUI;
            default:   legal  = 1'b0;
        endcase
    end

    assign imm_value = sign_ext ? {{`HALF_WIDTH{imm16[`HALF_WIDTH-1]}}, imm16}
                                : {{`HALF_WIDTH{1'b0}}, imm16};

    // strobes, not yet qualified by clk_enable.
    assign write_control = instr_valid && legal;
    assign illegal_instr = instr_valid && !legal;

endmodule

`default_nettype wire

/* design/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                clk_enable,
    input  logic                instr_valid,
    input  mips_pkg::word_t     instr,
    output logic                result_valid,
    output logic                illegal,
    output mips_pkg::word_t     result,
    output mips_pkg::reg_addr_t result_reg
);

    // ******************************
    // internal nets.
    // ******************************

    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t dest_reg;
    mips_pkg::shamt_t    shamt;
    mips_pkg::alu_op_t   alu_op;
    logic                use_imm;
    mips_pkg::word_t     imm_value;
    logic                write_control;
    logic                illegal_instr;
    mips_pkg::word_t     read_data1;
    mips_pkg::word_t     read_data2;
    mips_pkg::word_t     operand_b;
    mips_pkg::word_t     alu_result;

    instr_decode decode_i (
        .instr         (instr),
        .instr_valid   (instr_valid),
        .rs            (rs),
        .rt            (rt),
        .dest_reg      (dest_reg),
        .shamt         (shamt),
        .alu_op        (alu_op),
        .use_imm       (use_imm),
        .imm_value     (imm_value),
        .write_control (write_control),
        .illegal_instr (illegal_instr)
    );

    // writeback lands on the accepting edge.
    regfile regfile_i (
        .clk           (clk),
        .reset         (reset),
        .clk_enable    (clk_enable),
        .write_control (write_control),
        .read_reg1     (rs),
        .read_reg2     (rt),
        .write_reg     (dest_reg),
        .write_data    (alu_result),
        .read_data1    (read_data1),
        .read_data2    (read_data2)
    );

    // immediate or rt as second operand.
    assign operand_b = use_imm ? imm_value : read_data2;

    alu alu_i (
        .operand_a  (read_data1),
        .operand_b  (operand_b),
        .shamt      (shamt),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    // ******************************
    // output registers.
    // ******************************

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            illegal      <= 1'b0;
            result       <= '0;
            result_reg   <= '0;
        end else if (clk_enable) begin
            result_valid <= write_control;
            illegal      <= illegal_instr;
            if (write_control) begin
                result     <= alu_result;
                result_reg <= dest_reg;
            end
        end else begin
            // stalled, payload holds.
            result_valid <= 1'b0;
            illegal      <= 1'b0;
        end
    end

    valid_vs_illegal: assert property (
        @(posedge clk) disable iff (reset)
        !(result_valid && illegal)
    ) else $error("result_valid and illegal high together");

endmodule

`default_nettype wire

/* tests/exec_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb;

    localparam int clk_period = 8;
    localparam string case_file = "tests/exec_cases.txt";

    logic                clk;
    logic                reset;
    logic                clk_enable;
    logic                instr_valid;
    mips_pkg::word_t     instr;
    logic                result_valid;
    logic                illegal;
    mips_pkg::word_t     result;
    mips_pkg::reg_addr_t result_reg;

    // one entry per case line.
    bit          cen_q[$];
    bit          valid_q[$];
    logic [31:0] instr_q[$];
    bit          exp_valid_q[$];
    bit          exp_illegal_q[$];
    logic [31:0] exp_result_q[$];
    logic [4:0]  exp_reg_q[$];

    int case_count;
    bit cases_loaded;

    exec_core dut_i (
        .clk          (clk),
        .reset        (reset),
        .clk_enable   (clk_enable),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .illegal      (illegal),
        .result       (result),
        .result_reg   (result_reg)
    );

    // ******************************
    // clock and watchdog.
    // ******************************

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // case lines plus slack for reset and drain.
    initial begin
        wait (cases_loaded);
        #((case_count + 10) * clk_period);
        $display("timeout: run did not end within %0d cycles", case_count + 10);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // ******************************
    // helpers.
    // ******************************

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %0d ns: %s expected %h got %h", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        int          cen;
        int          val;
        int          ev;
        int          ei;
        int          rnum;
        logic [31:0] ins;
        logic [31:0] res;
        string       line;

        fd = $fopen(case_file, "r");
        if (fd == 0) begin
            $display("could not open the case file %s", case_file);
            $display("Simulation failed");
            $fatal(1, "missing case file");
        end
        while ($fgets(line, fd) > 0) begin
            // skip comments and blank lines.
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %h %d %d %h %d", cen, val, ins, ev, ei, res, rnum);
            if (n != 7) begin
                $display("case file line has %0d fields instead of 7: %s", n, line);
                $display("Simulation failed");
                $fatal(1, "bad case line");
            end
            cen_q.push_back(cen[0]);
            valid_q.push_back(val[0]);
            instr_q.push_back(ins);
            exp_valid_q.push_back(ev[0]);
            exp_illegal_q.push_back(ei[0]);
            exp_result_q.push_back(res);
            exp_reg_q.push_back(rnum[4:0]);
        end
        $fclose(fd);
        case_count = cen_q.size();
    endtask

    task automatic drive_inputs(input int idx);
        clk_enable  = cen_q[idx];
        instr_valid = valid_q[idx];
        instr       = instr_q[idx];
    endtask

    // payload is only meaningful with a result.
    task automatic check_outputs(input int idx);
        check_value("result_valid", exp_valid_q[idx], result_valid);
        check_value("illegal", exp_illegal_q[idx], illegal);
        if (exp_valid_q[idx]) begin
            check_value("result", exp_result_q[idx], result);
            check_value("result_reg", exp_reg_q[idx], result_reg);
        end
    endtask

    // ******************************
    // main sequence.
    // ******************************

    initial begin
        reset       = 1'b1;
        clk_enable  = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        case_count  = 0;

        load_cases();
        if (case_count == 0) begin
            $display("the case file holds no cases");
            $display("Simulation failed");
            $fatal(1, "empty case file");
        end
        cases_loaded = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // outputs cleared by reset.
        check_value("result_valid", 32'd0, result_valid);
        check_value("illegal", 32'd0, illegal);
        check_value("result", 32'd0, result);
        check_value("result_reg", 32'd0, result_reg);

        // expected values apply one cycle after the line is driven.
        for (int i = 0; i < case_count; i++) begin
            drive_inputs(i);
            @(negedge clk);
            check_outputs(i);
        end

        clk_enable  = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        @(negedge clk);

        $display("checked %0d case lines", case_count);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/exec_cases.txt */
# clk_enable instr_valid instr_hex | exp_result_valid exp_illegal exp_result_hex exp_result_reg
# expected columns apply to the cycle after the line is driven; result_reg is decimal.
1 0 00000000 0 0 00000000 0
# after reset every register reads zero.
1 1 00e02825 1 0 00000000 5
# immediates, sign and zero extension, lui.
1 1 24011234 1 0 00001234 1
1 1 2402ffff 1 0 ffffffff 2
1 1 34038000 1 0 00008000 3
1 1 3c048765 1 0 87650000 4
# reads $4 written one cycle earlier.
1 1 34844321 1 0 87654321 4
# r-type arithmetic and logic.
1 1 00222821 1 0 00001233 5
1 1 00243023 1 0 789acf13 6
1 1 00823824 1 0 87654321 7
1 1 00234025 1 0 00009234 8
1 1 00824826 1 0 789abcde 9
1 1 00235027 1 0 ffff6dcb 10
# signed and unsigned compares.
1 1 0081582a 1 0 00000001 11
1 1 0081602b 1 0 00000000 12
1 1 282dffff 1 0 00000000 13
1 1 2c2effff 1 0 00000001 14
1 1 284f0000 1 0 00000001 15
# shifts, sra on a negative and a positive value.
1 1 00018100 1 0 00012340 16
1 1 00048a02 1 0 00876543 17
1 1 00049203 1 0 ff876543 18
1 1 00019903 1 0 00000123 19
# andi zero-extends, xori reads the value just written.
1 1 30548001 1 0 00008001 20
1 1 3a94ffff 1 0 00007ffe 20
# write to $0 reports the value, a read of $0 still gives zero.
1 1 24200005 1 0 00001239 0
1 1 0001a821 1 0 00001234 21
# unsupported opcode aimed at $1, then $1 read back.
1 1 20017777 0 1 00000000 0
1 1 0020b025 1 0 00001234 22
# unsupported funct aimed at $2, then $2 read back.
1 1 00211020 0 1 00000000 0
1 1 0040b821 1 0 ffffffff 23
# stalled strobe aimed at $3 is dropped.
0 1 24035555 0 0 00000000 0
0 0 00000000 0 0 00000000 0
1 1 0060c025 1 0 00008000 24
1 0 00000000 0 0 00000000 0
1 1 0000c827 1 0 ffffffff 25
1 0 00000000 0 0 00000000 0

/* build.f */
+incdir+common
common/mips_pkg.sv
design/regfile.sv
design/alu.sv
design/instr_decode.sv
design/exec_core.sv
tests/exec_core_tb.sv

/* Bender.yml */
package:
  name: exec_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mips_pkg.sv
      - design/regfile.sv
      - design/alu.sv
      - design/instr_decode.sv
      - design/exec_core.sv

  - target: test
    include_dirs:
      - common
    files:
      - tests/exec_core_tb.sv
